// File: frontend.f
verilog/frontend_pkg.sv
verilog/frontend_if.sv
verilog/bpu.sv
verilog/icache.sv
verilog/ifu.sv
verilog/frontend.sv
sim/frontend_asserts.sv
sim/frontend_tb.sv

// File: sim/frontend_asserts.sv
// Protocol and stability assertions for the fetch frontend, bound into its top level
module frontend_asserts import frontend_pkg::*; (
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic                                 flush_i,
  input logic                                 ibuffer_valid_i,
  input logic                                 ibuffer_ready_i,
  input logic [INSTR_PER_FETCH-1:0][ILEN-1:0] ibuffer_data_i,
  input logic [PLEN-1:0]                      ibuffer_pc_i,
  input logic [INSTR_PER_FETCH-1:0]           ibuffer_slot_valid_i,
  input logic [INSTR_PER_FETCH-1:0][PLEN-1:0] ibuffer_pred_npc_i,
  input logic                                 miss_req_valid_i,
  input logic                                 miss_req_ready_i,
  input logic [PLEN-1:0]                      miss_req_paddr_i,
  input logic                                 refill_ready_i,
  input logic                                 hit_window_i
);

  int fail_cnt = 0;

  // Outputs idle in the cycle after reset
  reset_idle: assert property (@(posedge clk_i)
    reset_i |=> !ibuffer_valid_i && !miss_req_valid_i && !refill_ready_i)
    else begin
      $error("frontend outputs active right after reset");
      fail_cnt++;
    end

  // ==================================================
  // Instruction buffer
  // ==================================================
  ibuf_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    ibuffer_valid_i && !ibuffer_ready_i && !flush_i |=>
      ibuffer_valid_i && $stable(ibuffer_data_i) && $stable(ibuffer_pc_i) &&
      $stable(ibuffer_slot_valid_i) && $stable(ibuffer_pred_npc_i))
    else begin
      $error("instruction buffer group changed while stalled");
      fail_cnt++;
    end

  // ==================================================
  // Miss request
  // ==================================================
  miss_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_valid_i |-> miss_req_paddr_i[LINE_OFF_W-1:0] == '0)
    else begin
      $error("miss address not line aligned");
      fail_cnt++;
    end

  miss_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_valid_i && !miss_req_ready_i |=>
      miss_req_valid_i && $stable(miss_req_paddr_i))
    else begin
      $error("miss request dropped or changed before ready");
      fail_cnt++;
    end

  // Refetch of cached lines must not go to memory
  no_miss_in_window: assert property (@(posedge clk_i) disable iff (reset_i)
    hit_window_i |-> !miss_req_valid_i)
    else begin
      $error("miss request raised while refetching cached lines");
      fail_cnt++;
    end

endmodule

// File: sim/frontend_tb.sv
// Frontend testbench with memory and backend models, directed fetch scenarios and scoreboard
module frontend_tb import frontend_pkg::*; ();

  logic                                 clk;
  logic                                 reset;
  logic                                 ibuf_valid;
  logic                                 ibuf_ready;
  logic [INSTR_PER_FETCH-1:0][ILEN-1:0] ibuf_data;
  logic [PLEN-1:0]                      ibuf_pc;
  logic [INSTR_PER_FETCH-1:0]           ibuf_slot_valid;
  logic [INSTR_PER_FETCH-1:0][PLEN-1:0] ibuf_pred_npc;
  logic                                 flush;
  logic [PLEN-1:0]                      redirect_pc;
  logic                                 upd_valid;
  logic [PLEN-1:0]                      upd_pc;
  logic                                 upd_is_cond;
  logic                                 upd_taken;
  logic [PLEN-1:0]                      upd_target;
  logic                                 miss_valid;
  logic                                 miss_ready;
  logic [PLEN-1:0]                      miss_paddr;
  logic                                 refill_valid;
  logic                                 refill_ready;
  logic [LINE_WIDTH-1:0]                refill_data;

  // Delivered groups and miss addresses, oldest first
  logic [PLEN-1:0]                      grp_pc_q[$];
  logic [INSTR_PER_FETCH-1:0]           grp_sv_q[$];
  logic [INSTR_PER_FETCH-1:0][PLEN-1:0] grp_npc_q[$];
  logic [PLEN-1:0]                      miss_log_q[$];

  logic [31:0]     lfsr;
  int              ready_mode;
  int              mem_state;
  int              mem_delay;
  logic [PLEN-1:0] mem_line;
  logic            refill_seen;
  logic            hit_window;
  int              err_cnt;
  int              timeout_cnt;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  frontend frontend_inst (
    .clk_i(clk), .reset_i(reset),
    .ibuffer_valid_o(ibuf_valid), .ibuffer_ready_i(ibuf_ready),
    .ibuffer_data_o(ibuf_data), .ibuffer_pc_o(ibuf_pc),
    .ibuffer_slot_valid_o(ibuf_slot_valid), .ibuffer_pred_npc_o(ibuf_pred_npc),
    .flush_i(flush), .redirect_pc_i(redirect_pc),
    .bpu_update_valid_i(upd_valid), .bpu_update_pc_i(upd_pc),
    .bpu_update_is_cond_i(upd_is_cond), .bpu_update_taken_i(upd_taken),
    .bpu_update_target_i(upd_target),
    .miss_req_valid_o(miss_valid), .miss_req_ready_i(miss_ready),
    .miss_req_paddr_o(miss_paddr),
    .refill_valid_i(refill_valid), .refill_ready_o(refill_ready),
    .refill_data_i(refill_data)
  );

  bind frontend frontend_asserts asserts_inst (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(flush_i),
    .ibuffer_valid_i(ibuffer_valid_o), .ibuffer_ready_i(ibuffer_ready_i),
    .ibuffer_data_i(ibuffer_data_o), .ibuffer_pc_i(ibuffer_pc_o),
    .ibuffer_slot_valid_i(ibuffer_slot_valid_o), .ibuffer_pred_npc_i(ibuffer_pred_npc_o),
    .miss_req_valid_i(miss_req_valid_o), .miss_req_ready_i(miss_req_ready_i),
    .miss_req_paddr_i(miss_req_paddr_o), .refill_ready_i(refill_ready_o),
    .hit_window_i(frontend_tb.hit_window)
  );

  // Memory content is the byte address with a fixed mask
  function automatic logic [ILEN-1:0] mem_word(input logic [PLEN-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [LINE_WIDTH-1:0] build_line(input logic [PLEN-1:0] base);
    logic [LINE_WIDTH-1:0] line;
    for (int w = 0; w < LINE_WIDTH / ILEN; w++) begin
      line[w*ILEN +: ILEN] = mem_word(base + PLEN'(4 * w));
    end
    return line;
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // ==================================================
  // Backend ready and memory model
  // ==================================================
  // Memory states 0 idle, 1 delay, 2 accepted, 3 refill
  always @(posedge clk) begin
    #10;
    case (ready_mode)
      0: ibuf_ready = 1'b0;
      1: ibuf_ready = |rand_bits(2);
      default: ibuf_ready = 1'b1;
    endcase
    case (mem_state)
      0: begin
        if (miss_valid === 1'b1) begin
          mem_line  = miss_paddr;
          mem_delay = rand_bits(3);
          mem_state = 1;
        end
      end
      1: begin
        if (mem_delay == 0) begin
          miss_ready = 1'b1;
          mem_state  = 2;
        end else begin
          mem_delay--;
        end
      end
      2: begin
        miss_ready   = 1'b0;
        refill_data  = build_line(mem_line);
        refill_valid = 1'b1;
        mem_state    = 3;
      end
      default: begin
        if (refill_seen) begin
          refill_valid = 1'b0;
          mem_state    = 0;
        end
      end
    endcase
    refill_seen = refill_ready;
  end

  // Scoreboard sampling at the falling edge, when all signals are settled
  always @(negedge clk) begin
    if (!reset && miss_valid && miss_ready) begin
      miss_log_q.push_back(miss_paddr);
    end
    if (!reset && !flush && ibuf_valid && ibuf_ready) begin
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        if (ibuf_slot_valid[s]) begin
          compare_word(ibuf_data[s], mem_word({ibuf_pc[PLEN-1:3], 3'b000} + PLEN'(4 * s)),
                       "slot data");
        end
      end
      grp_pc_q.push_back(ibuf_pc);
      grp_sv_q.push_back(ibuf_slot_valid);
      grp_npc_q.push_back(ibuf_pred_npc);
    end
  end

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic set_mode(input int m);
    @(posedge clk);
    #5;
    ready_mode = m;
  endtask

  task automatic wait_groups(input int n);
    int cycles;
    cycles = 0;
    while (grp_pc_q.size() < n && cycles < 600) begin
      @(posedge clk);
      #5;
      cycles++;
    end
    if (grp_pc_q.size() < n) begin
      $display("Timeout at %0t: %0d of %0d groups arrived", $time, grp_pc_q.size(), n);
      timeout_cnt++;
    end
  endtask

  // Quiet for a few cycles so no miss is about to start
  task automatic wait_memory_idle();
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    while (quiet < 4 && cycles < 600) begin
      @(posedge clk);
      #5;
      cycles++;
      if (mem_state == 0 && !miss_valid && !refill_ready) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < 4) begin
      $display("Timeout at %0t: memory never went idle", $time);
      timeout_cnt++;
    end
  endtask

  task automatic redirect_to(input logic [PLEN-1:0] addr);
    @(posedge clk);
    #10;
    flush       = 1'b1;
    redirect_pc = addr;
    @(posedge clk);
    #10;
    flush = 1'b0;
    grp_pc_q.delete();
    grp_sv_q.delete();
    grp_npc_q.delete();
    miss_log_q.delete();
  endtask

  task automatic train(input logic [PLEN-1:0] pc, input logic [PLEN-1:0] target,
                       input logic taken);
    @(posedge clk);
    #10;
    upd_valid   = 1'b1;
    upd_pc      = pc;
    upd_is_cond = 1'b1;
    upd_taken   = taken;
    upd_target  = target;
    @(posedge clk);
    #10;
    upd_valid = 1'b0;
  endtask

  task automatic check_group(input int i, input logic [PLEN-1:0] pc,
                             input logic [INSTR_PER_FETCH-1:0] sv,
                             input logic [PLEN-1:0] npc);
    if (i < grp_pc_q.size()) begin
      compare_word(grp_pc_q[i], pc, "group pc");
      compare_word(32'(grp_sv_q[i]), 32'(sv), "slot valid");
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        compare_word(grp_npc_q[i][s], npc, "predicted npc");
      end
    end
  endtask

  // Fetch one group at a line, then stall and let memory settle
  task automatic visit_line(input logic [PLEN-1:0] line, input int exp_misses);
    int misses;
    redirect_to(line);
    set_mode(1);
    wait_groups(1);
    set_mode(0);
    wait_memory_idle();
    check_group(0, line, 2'b11, line + 32'd8);
    misses = 0;
    foreach (miss_log_q[k]) begin
      if (miss_log_q[k] == line) begin
        misses++;
      end
    end
    compare_word(misses, exp_misses, "line misses");
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    reset        = 1'b1;
    flush        = 1'b0;
    redirect_pc  = '0;
    upd_valid    = 1'b0;
    upd_pc       = '0;
    upd_is_cond  = 1'b0;
    upd_taken    = 1'b0;
    upd_target   = '0;
    ibuf_ready   = 1'b0;
    miss_ready   = 1'b0;
    refill_valid = 1'b0;
    refill_data  = '0;
    lfsr         = 32'h415a8754;
    ready_mode   = 0;
    mem_state    = 0;
    mem_delay    = 0;
    mem_line     = '0;
    refill_seen  = 1'b0;
    hit_window   = 1'b0;
    err_cnt      = 0;
    timeout_cnt  = 0;
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;

    // Sequential fetch from the reset PC
    set_mode(1);
    wait_groups(8);
    set_mode(0);
    for (int i = 0; i < 8; i++) begin
      check_group(i, RESET_PC + PLEN'(8 * i), 2'b11, RESET_PC + PLEN'(8 * i + 8));
    end

    // Refetch of cached lines stays inside the cache
    redirect_to(RESET_PC);
    wait_memory_idle();
    hit_window = 1'b1;
    miss_log_q.delete();
    set_mode(1);
    wait_groups(6);
    set_mode(0);
    wait_memory_idle();
    hit_window = 1'b0;
    compare_word(miss_log_q.size(), 0, "refetch misses");
    for (int i = 0; i < 6; i++) begin
      check_group(i, RESET_PC + PLEN'(8 * i), 2'b11, RESET_PC + PLEN'(8 * i + 8));
    end

    // Taken branch in slot 0, then trained back to not taken
    train(32'h0000_1010, 32'h0000_3000, 1'b1);
    redirect_to(32'h0000_1010);
    set_mode(1);
    wait_groups(2);
    set_mode(0);
    check_group(0, 32'h0000_1010, 2'b01, 32'h0000_3000);
    check_group(1, 32'h0000_3000, 2'b11, 32'h0000_3008);
    train(32'h0000_1010, 32'h0000_3000, 1'b0);
    train(32'h0000_1010, 32'h0000_3000, 1'b0);
    redirect_to(32'h0000_1010);
    set_mode(1);
    wait_groups(2);
    set_mode(0);
    check_group(0, 32'h0000_1010, 2'b11, 32'h0000_1018);
    check_group(1, 32'h0000_1018, 2'b11, 32'h0000_1020);

    // Flush while misses are in flight
    redirect_to(32'h0000_7000);
    set_mode(1);
    wait_groups(1);
    redirect_to(32'h0000_2000);
    wait_groups(2);
    set_mode(0);
    check_group(0, 32'h0000_2000, 2'b11, 32'h0000_2008);
    check_group(1, 32'h0000_2008, 2'b11, 32'h0000_2010);
    wait_memory_idle();

    // Three lines in set 8, then the oldest and the newest again
    visit_line(32'h0000_4080, 1);
    visit_line(32'h0000_5080, 1);
    visit_line(32'h0000_6080, 1);
    visit_line(32'h0000_4080, 1);
    visit_line(32'h0000_6080, 0);

    $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
             err_cnt, frontend_inst.asserts_inst.fail_cnt, timeout_cnt);
    if (err_cnt + frontend_inst.asserts_inst.fail_cnt + timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verilog/bpu.sv
// Branch target buffer with 2-bit counters predicting the next fetch address
module bpu import frontend_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  bpu_if.pred             pred_i,
  input  logic            update_valid_i,
  input  logic [PLEN-1:0] update_pc_i,
  input  logic            update_is_cond_i,
  input  logic            update_taken_i,
  input  logic [PLEN-1:0] update_target_i
);

  // One bank per slot, indexed by the group bits above the slot
  logic [BTB_ENTRIES-1:0] valid_q [INSTR_PER_FETCH];
  logic [BTB_ENTRIES-1:0] cond_q  [INSTR_PER_FETCH];
  logic [BTB_TAG_W-1:0]   tag_q   [INSTR_PER_FETCH][BTB_ENTRIES];
  logic [PLEN-1:0]        target_q[INSTR_PER_FETCH][BTB_ENTRIES];
  logic [1:0]             ctr_q   [INSTR_PER_FETCH][BTB_ENTRIES];

  fetch_addr_u                pc_a;
  fetch_addr_u                upd_a;
  logic [INSTR_PER_FETCH-1:0] slot_taken;
  logic                       upd_hit;

  assign pc_a  = pred_i.pc;
  assign upd_a = update_pc_i;

  // ==================================================
  // Lookup
  // ==================================================
  always_comb begin
    pred_i.pred_slot_valid = 1'b0;
    pred_i.pred_slot_idx   = '0;
    pred_i.pred_target     = '0;
    // Walk down so the lowest taken slot wins
    for (int s = INSTR_PER_FETCH - 1; s >= 0; s--) begin
      slot_taken[s] = valid_q[s][pc_a.bp.idx] &&
                      (tag_q[s][pc_a.bp.idx] == pc_a.bp.tag) &&
                      (s >= pc_a.bp.slot) &&
                      (!cond_q[s][pc_a.bp.idx] || ctr_q[s][pc_a.bp.idx][1]);
      if (slot_taken[s]) begin
        pred_i.pred_slot_valid = 1'b1;
        pred_i.pred_slot_idx   = SLOT_W'(s);
        pred_i.pred_target     = target_q[s][pc_a.bp.idx];
      end
    end
    if (pred_i.pred_slot_valid) begin
      pred_i.npc = pred_i.pred_target;
    end else begin
      pred_i.npc = {pc_a[PLEN-1:3], 3'b000} + PLEN'(8);
    end
  end

  // ==================================================
  // Training
  // ==================================================
  assign upd_hit = valid_q[upd_a.bp.slot][upd_a.bp.idx] &&
                   (tag_q[upd_a.bp.slot][upd_a.bp.idx] == upd_a.bp.tag);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        valid_q[s] <= '0;
      end
    end else if (update_valid_i) begin
      if (upd_hit) begin
        cond_q[upd_a.bp.slot][upd_a.bp.idx] <= update_is_cond_i;
        if (update_taken_i) begin
          target_q[upd_a.bp.slot][upd_a.bp.idx] <= update_target_i;
          if (ctr_q[upd_a.bp.slot][upd_a.bp.idx] != 2'd3) begin
            ctr_q[upd_a.bp.slot][upd_a.bp.idx] <= ctr_q[upd_a.bp.slot][upd_a.bp.idx] + 2'd1;
          end
        end else if (ctr_q[upd_a.bp.slot][upd_a.bp.idx] != 2'd0) begin
          ctr_q[upd_a.bp.slot][upd_a.bp.idx] <= ctr_q[upd_a.bp.slot][upd_a.bp.idx] - 2'd1;
        end
      end else if (update_taken_i) begin
        // Allocate, weakly taken
        valid_q[upd_a.bp.slot][upd_a.bp.idx]  <= 1'b1;
        tag_q[upd_a.bp.slot][upd_a.bp.idx]    <= upd_a.bp.tag;
        target_q[upd_a.bp.slot][upd_a.bp.idx] <= update_target_i;
        cond_q[upd_a.bp.slot][upd_a.bp.idx]   <= update_is_cond_i;
        ctr_q[upd_a.bp.slot][upd_a.bp.idx]    <= 2'd2;
      end
    end
  end

endmodule

// File: verilog/frontend.sv
// Instruction fetch frontend joining fetch unit, branch predictor and instruction cache
module frontend import frontend_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  // ==================================================
  // Instruction buffer and backend control
  // ==================================================
  output logic                                 ibuffer_valid_o,
  input  logic                                 ibuffer_ready_i,
  output logic [INSTR_PER_FETCH-1:0][ILEN-1:0] ibuffer_data_o,
  output logic [PLEN-1:0]                      ibuffer_pc_o,
  output logic [INSTR_PER_FETCH-1:0]           ibuffer_slot_valid_o,
  output logic [INSTR_PER_FETCH-1:0][PLEN-1:0] ibuffer_pred_npc_o,
  input  logic                                 flush_i,
  input  logic [PLEN-1:0]                      redirect_pc_i,
  input  logic                                 bpu_update_valid_i,
  input  logic [PLEN-1:0]                      bpu_update_pc_i,
  input  logic                                 bpu_update_is_cond_i,
  input  logic                                 bpu_update_taken_i,
  input  logic [PLEN-1:0]                      bpu_update_target_i,

  // ==================================================
  // Memory side
  // ==================================================
  output logic                                 miss_req_valid_o,
  input  logic                                 miss_req_ready_i,
  output logic [PLEN-1:0]                      miss_req_paddr_o,
  input  logic                                 refill_valid_i,
  output logic                                 refill_ready_o,
  input  logic [LINE_WIDTH-1:0]                refill_data_i
);

  icache_if cache_bus ();
  bpu_if    pred_bus ();

  ifu ifu_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cache_o             (cache_bus.fetch),
    .pred_o              (pred_bus.fetch),
    .flush_i             (flush_i),
    .redirect_pc_i       (redirect_pc_i),
    .ibuffer_valid_o     (ibuffer_valid_o),
    .ibuffer_ready_i     (ibuffer_ready_i),
    .ibuffer_data_o      (ibuffer_data_o),
    .ibuffer_pc_o        (ibuffer_pc_o),
    .ibuffer_slot_valid_o(ibuffer_slot_valid_o),
    .ibuffer_pred_npc_o  (ibuffer_pred_npc_o)
  );

  bpu bpu_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .pred_i          (pred_bus.pred),
    .update_valid_i  (bpu_update_valid_i),
    .update_pc_i     (bpu_update_pc_i),
    .update_is_cond_i(bpu_update_is_cond_i),
    .update_taken_i  (bpu_update_taken_i),
    .update_target_i (bpu_update_target_i)
  );

  icache icache_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_i         (cache_bus.cache),
    .miss_req_valid_o(miss_req_valid_o),
    .miss_req_ready_i(miss_req_ready_i),
    .miss_req_paddr_o(miss_req_paddr_o),
    .refill_valid_i  (refill_valid_i),
    .refill_ready_o  (refill_ready_o),
    .refill_data_i   (refill_data_i)
  );

endmodule

// File: verilog/frontend_if.sv
// Fetch-to-cache and fetch-to-predictor interfaces with their modports

// ==================================================
// Fetch unit to instruction cache
// ==================================================
interface icache_if import frontend_pkg::*; ();
  logic                                  req_valid;
  logic                                  req_ready;
  logic [PLEN-1:0]                       req_pc;
  logic                                  rsp_valid;
  logic                                  rsp_ready;
  logic [INSTR_PER_FETCH-1:0][ILEN-1:0]  rsp_data;
  // Kills the accepted request that has not answered yet
  logic                                  flush;

  modport fetch (output req_valid, req_pc, rsp_ready, flush,
                 input  req_ready, rsp_valid, rsp_data);
  modport cache (input  req_valid, req_pc, rsp_ready, flush,
                 output req_ready, rsp_valid, rsp_data);
endinterface

// ==================================================
// Fetch unit to branch predictor
// ==================================================
interface bpu_if import frontend_pkg::*; ();
  logic [PLEN-1:0]   pc;
  logic [PLEN-1:0]   npc;
  logic              pred_slot_valid;
  logic [SLOT_W-1:0] pred_slot_idx;
  logic [PLEN-1:0]   pred_target;

  // Same-cycle answer, no handshake
  modport fetch (output pc,
                 input  npc, pred_slot_valid, pred_slot_idx, pred_target);
  modport pred  (input  pc,
                 output npc, pred_slot_valid, pred_slot_idx, pred_target);
endinterface

// File: verilog/frontend_pkg.sv
// Frontend package with fetch widths, cache and predictor sizes, and the fetch address views
package frontend_pkg;

  // ==================================================
  // Core widths
  // ==================================================
  localparam int PLEN = 32;
  localparam int ILEN = 32;
  localparam int INSTR_PER_FETCH = 2;
  localparam int GROUP_W = INSTR_PER_FETCH * ILEN;
  localparam int SLOT_W = $clog2(INSTR_PER_FETCH);
  localparam logic [PLEN-1:0] RESET_PC = 32'h0000_1000;

  // ==================================================
  // Cache and predictor geometry
  // ==================================================
  localparam int LINE_WIDTH = 128;
  localparam int LINE_OFF_W = $clog2(LINE_WIDTH / 8);
  localparam int ICACHE_SETS = 16;
  localparam int ICACHE_WAYS = 2;
  localparam int ICACHE_IDX_W = $clog2(ICACHE_SETS);
  localparam int ICACHE_TAG_W = PLEN - ICACHE_IDX_W - LINE_OFF_W;
  localparam int WAY_W = $clog2(ICACHE_WAYS);
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W = PLEN - BTB_IDX_W - SLOT_W - 2;

  // Cache controller states
  localparam logic [1:0] IC_IDLE = 2'd0;
  localparam logic [1:0] IC_LOOKUP = 2'd1;
  localparam logic [1:0] IC_MISS = 2'd2;
  localparam logic [1:0] IC_REFILL = 2'd3;

  // One PC, split for the cache or for the branch target buffer
  typedef union packed {
    struct packed {
      logic [ICACHE_TAG_W-1:0] tag;
      logic [ICACHE_IDX_W-1:0] set;
      logic [1:0]              word;
      logic [1:0]              offset;
    } ic;
    struct packed {
      logic [BTB_TAG_W-1:0] tag;
      logic [BTB_IDX_W-1:0] idx;
      logic [SLOT_W-1:0]    slot;
      logic [1:0]           offset;
    } bp;
  } fetch_addr_u;

endpackage

// File: verilog/icache.sv
// Instruction cache, 2-way set-associative with LRU and one outstanding line refill
module icache import frontend_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  icache_if.cache               fetch_i,
  output logic                  miss_req_valid_o,
  input  logic                  miss_req_ready_i,
  output logic [PLEN-1:0]       miss_req_paddr_o,
  input  logic                  refill_valid_i,
  output logic                  refill_ready_o,
  input  logic [LINE_WIDTH-1:0] refill_data_i
);

  // ==================================================
  // Arrays
  // ==================================================
  logic [ICACHE_TAG_W-1:0] tag_q  [ICACHE_WAYS][ICACHE_SETS];
  logic [LINE_WIDTH-1:0]   data_q [ICACHE_WAYS][ICACHE_SETS];
  logic [ICACHE_SETS-1:0]  valid_q[ICACHE_WAYS];
  // Least recently used way of each set
  logic [WAY_W-1:0]        lru_q  [ICACHE_SETS];

  logic [1:0]  state_q;
  fetch_addr_u req_q;
  logic        kill_q;

  logic [ICACHE_WAYS-1:0] hit_way;
  logic                   hit;
  logic [WAY_W-1:0]       hit_idx;
  logic [WAY_W-1:0]       victim;
  logic [LINE_WIDTH-1:0]  hit_line;
  logic                   lookup;
  logic                   req_fire;
  logic                   rsp_fire;
  logic                   miss_fire;
  logic                   refill_fire;
  logic                   miss_open;

  // Tag compare on the held request
  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < ICACHE_WAYS; w++) begin
      hit_way[w] = valid_q[w][req_q.ic.set] && (tag_q[w][req_q.ic.set] == req_q.ic.tag);
      if (hit_way[w]) begin
        hit_idx = WAY_W'(w);
      end
    end
    hit      = |hit_way;
    hit_line = data_q[hit_idx][req_q.ic.set];
  end

  // Invalid way first, else the LRU way
  always_comb begin
    victim = lru_q[req_q.ic.set];
    for (int w = ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][req_q.ic.set]) begin
        victim = WAY_W'(w);
      end
    end
  end

  // ==================================================
  // Handshakes
  // ==================================================
  assign lookup            = (state_q == IC_LOOKUP);
  assign fetch_i.rsp_valid = lookup && hit;
  assign fetch_i.rsp_data  = req_q.ic.word[1] ? hit_line[LINE_WIDTH-1 -: GROUP_W]
                                              : hit_line[GROUP_W-1:0];
  // A new request may enter as the response leaves
  assign fetch_i.req_ready = (state_q == IC_IDLE) || (fetch_i.rsp_valid && fetch_i.rsp_ready);

  assign req_fire    = fetch_i.req_valid && fetch_i.req_ready;
  assign rsp_fire    = fetch_i.rsp_valid && fetch_i.rsp_ready;
  assign miss_fire   = miss_req_valid_o && miss_req_ready_i;
  assign refill_fire = refill_valid_i && refill_ready_o;

  assign miss_req_valid_o = (lookup && !hit) || (state_q == IC_MISS);
  assign miss_req_paddr_o = {req_q.ic.tag, req_q.ic.set, {LINE_OFF_W{1'b0}}};
  assign refill_ready_o   = (state_q == IC_REFILL);
  assign miss_open        = miss_req_valid_o || refill_ready_o;

  // ==================================================
  // Control
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IC_IDLE;
      kill_q  <= 1'b0;
      for (int w = 0; w < ICACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
      for (int i = 0; i < ICACHE_SETS; i++) begin
        lru_q[i] <= '0;
      end
    end else begin
      case (state_q)
        IC_IDLE: begin
          if (req_fire) begin
            state_q <= IC_LOOKUP;
          end
        end
        IC_LOOKUP: begin
          if (!hit) begin
            // Miss goes out even under flush, its answer is dropped later
            state_q <= miss_fire ? IC_REFILL : IC_MISS;
          end else if (fetch_i.flush) begin
            state_q <= IC_IDLE;
          end else if (rsp_fire) begin
            lru_q[req_q.ic.set] <= ~hit_idx;
            state_q <= req_fire ? IC_LOOKUP : IC_IDLE;
          end
        end
        IC_MISS: begin
          if (miss_req_ready_i) begin
            state_q <= IC_REFILL;
          end
        end
        default: begin
          if (refill_fire) begin
            valid_q[victim][req_q.ic.set] <= 1'b1;
            state_q <= (kill_q || fetch_i.flush) ? IC_IDLE : IC_LOOKUP;
          end
        end
      endcase

      if (refill_fire) begin
        kill_q <= 1'b0;
      end else if (fetch_i.flush && miss_open) begin
        kill_q <= 1'b1;
      end
    end
  end

  // Request address and line storage
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= fetch_i.req_pc;
    end
    if (refill_fire) begin
      tag_q[victim][req_q.ic.set]  <= req_q.ic.tag;
      data_q[victim][req_q.ic.set] <= refill_data_i;
    end
  end

endmodule

// File: verilog/ifu.sv
// Fetch unit sequencing the PC, issuing cache requests and holding the group for the buffer
module ifu import frontend_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  icache_if.fetch                              cache_o,
  bpu_if.fetch                                 pred_o,
  input  logic                                 flush_i,
  input  logic [PLEN-1:0]                      redirect_pc_i,
  output logic                                 ibuffer_valid_o,
  input  logic                                 ibuffer_ready_i,
  output logic [INSTR_PER_FETCH-1:0][ILEN-1:0] ibuffer_data_o,
  output logic [PLEN-1:0]                      ibuffer_pc_o,
  output logic [INSTR_PER_FETCH-1:0]           ibuffer_slot_valid_o,
  output logic [INSTR_PER_FETCH-1:0][PLEN-1:0] ibuffer_pred_npc_o
);

  logic [PLEN-1:0] pc_q;
  // A request is in the cache
  logic            busy_q;

  // Prediction taken with the outstanding request
  fetch_addr_u       pend_pc_q;
  logic              pend_slot_valid_q;
  logic [SLOT_W-1:0] pend_slot_idx_q;
  logic [PLEN-1:0]   pend_npc_q;

  logic                       req_fire;
  logic                       rsp_take;
  logic [INSTR_PER_FETCH-1:0] grp_slot_valid;

  // ==================================================
  // Requests
  // ==================================================
  assign pred_o.pc     = pc_q;
  assign cache_o.req_pc = pc_q;
  assign cache_o.flush = flush_i;

  // Output register empty or draining this cycle
  assign cache_o.rsp_ready = !ibuffer_valid_o || ibuffer_ready_i;
  assign rsp_take          = cache_o.rsp_valid && cache_o.rsp_ready;
  assign cache_o.req_valid = !flush_i && (!busy_q || rsp_take);
  assign req_fire          = cache_o.req_valid && cache_o.req_ready;

  // Slots before the PC, or after a predicted-taken slot, are dropped
  always_comb begin
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      grp_slot_valid[s] = (s >= pend_pc_q.bp.slot) &&
                          !(pend_slot_valid_q && (s > pend_slot_idx_q));
    end
  end

  // ==================================================
  // Control
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q            <= RESET_PC;
      busy_q          <= 1'b0;
      ibuffer_valid_o <= 1'b0;
    end else if (flush_i) begin
      pc_q            <= redirect_pc_i;
      busy_q          <= 1'b0;
      ibuffer_valid_o <= 1'b0;
    end else begin
      if (req_fire) begin
        pc_q   <= pred_o.npc;
        busy_q <= 1'b1;
      end else if (rsp_take) begin
        busy_q <= 1'b0;
      end
      if (rsp_take) begin
        ibuffer_valid_o <= 1'b1;
      end else if (ibuffer_ready_i) begin
        ibuffer_valid_o <= 1'b0;
      end
    end
  end

  // Pending prediction and output group
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      pend_pc_q         <= pc_q;
      pend_slot_valid_q <= pred_o.pred_slot_valid;
      pend_slot_idx_q   <= pred_o.pred_slot_idx;
      pend_npc_q        <= pred_o.npc;
    end
    if (rsp_take) begin
      ibuffer_data_o       <= cache_o.rsp_data;
      ibuffer_pc_o         <= pend_pc_q;
      ibuffer_slot_valid_o <= grp_slot_valid;
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        ibuffer_pred_npc_o[s] <= pend_npc_q;
      end
    end
  end

endmodule
